//--- sim.f
bp_pkg.sv
counter_table.sv
global_predictor.sv
tournament_chooser.sv
prediction_stats.sv
branch_predictor.sv
tb_branch_predictor.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass message
verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_branch_predictor \
	-o tb_branch_predictor \
	&& ./obj_dir/tb_branch_predictor | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor import bp_pkg::*; ();

	localparam int NUM_ENTRIES = 64;
	localparam int WAIT_LIMIT  = 10;

	logic      clk;
	logic      reset_i;
	bp_query_t query;
	bp_train_t train;
	bp_pred_t  pred;
	stat_t     branch_count;
	stat_t     mispredict_count;

	// stimulus table: pc, actual outcome, query overlaps previous train
	pc_t  pc_tab    [NUM_ENTRIES];
	logic taken_tab [NUM_ENTRIES];
	logic same_tab  [NUM_ENTRIES];
	int   n_entries;

	// reference model of all tables
	logic [1:0] local_m  [64];
	logic [1:0] global_m [64];
	logic [1:0] choice_m [64];
	logic [5:0] hist_m;
	int         branch_m;
	int         misp_m;

	// expected fields of the query in flight
	logic       exp_local;
	logic       exp_global;
	logic       exp_taken;
	logic [5:0] exp_hist;

	int   errors;
	int   checks;
	int   seed;
	logic timed_out;

	branch_predictor uut(
		.clk			(clk			),
		.reset_i		(reset_i		),
		.query_i		(query			),
		.train_i		(train			),
		.pred_o			(pred			),
		.branch_count_o		(branch_count		),
		.mispredict_count_o	(mispredict_count	)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	//****************************************
	// helpers
	//****************************************
	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic add_entry(input pc_t pc, input logic taken, input logic same);
		pc_tab[n_entries]    = pc;
		taken_tab[n_entries] = taken;
		same_tab[n_entries]  = same;
		n_entries++;
	endtask

	function automatic logic [1:0] saturate(input logic [1:0] ctr, input logic up);
		if (up) begin
			return (ctr == 2'd3) ? ctr : ctr + 2'd1;
		end
		return (ctr == 2'd0) ? ctr : ctr - 2'd1;
	endfunction

	// model prediction from the tables as they stand now
	task automatic predict_model(input pc_t pc);
		logic [5:0] idx;
		idx        = pc[7:2];
		exp_local  = local_m[idx] >= 2'd2;
		exp_global = global_m[idx ^ hist_m] >= 2'd2;
		exp_taken  = (choice_m[idx] >= 2'd2) ? exp_global : exp_local;
		exp_hist   = hist_m;
	endtask

	task automatic train_model(input bp_train_t t);
		logic [5:0] idx;
		idx                       = t.pc[7:2];
		local_m[idx]              = saturate(local_m[idx], t.taken);
		global_m[idx ^ t.history] = saturate(global_m[idx ^ t.history], t.taken);
		// chooser learns only from a split vote
		if (t.local_taken != t.global_taken) begin
			choice_m[idx] = saturate(choice_m[idx], t.global_taken == t.taken);
		end
		hist_m = {hist_m[4:0], t.taken};
		branch_m++;
		if (t.pred_taken != t.taken) begin
			misp_m++;
		end
	endtask

	task automatic wait_pred();
		int cycles;
		cycles = 0;
		while (!pred.valid && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!pred.valid) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout: no prediction came back within %0d cycles", WAIT_LIMIT);
		end
	endtask

	task automatic fill_table();
		int r;
		// local learning, then unlearning
		add_entry(32'h0000_0120, 1'b1, 1'b0);
		add_entry(32'h0000_0120, 1'b1, 1'b0);
		add_entry(32'h0000_0120, 1'b1, 1'b0);
		add_entry(32'h0000_0120, 1'b0, 1'b0);
		add_entry(32'h0000_0120, 1'b0, 1'b0);
		add_entry(32'h0000_0120, 1'b0, 1'b0);
		// alternating branch for the global side and the chooser
		for (int k = 0; k < 16; k++) begin
			add_entry(32'h0000_0240, k[0] == 1'b0, 1'b0);
		end
		// query and train to one index in the same cycle
		add_entry(32'h0000_0120, 1'b1, 1'b0);
		add_entry(32'h0000_0120, 1'b1, 1'b1);
		add_entry(32'h0000_0120, 1'b0, 1'b1);
		while (n_entries < NUM_ENTRIES) begin
			r = $random(seed);
			add_entry(32'h0000_1000 | (32'(r[1:0]) << 2), r[8], r[12]);
		end
	endtask

	//****************************************
	// main sequence
	//****************************************
	initial begin
		logic pending;
		reset_i   = 1'b1;
		query     = '0;
		train     = '0;
		errors    = 0;
		checks    = 0;
		n_entries = 0;
		seed      = 76355;
		timed_out = 1'b0;
		pending   = 1'b0;
		for (int i = 0; i < 64; i++) begin
			local_m[i]  = CTR_RESET;
			global_m[i] = CTR_RESET;
			choice_m[i] = CTR_RESET;
		end
		hist_m   = '0;
		branch_m = 0;
		misp_m   = 0;
		fill_table();

		repeat (5) @(posedge clk);
		#2;
		reset_i = 1'b0;

		// idle after reset
		for (int k = 0; k < 3; k++) begin
			check_field("pred_o.valid", 32'(pred.valid), 32'd0);
			check_field("branch_count_o", 32'(branch_count), 32'd0);
			check_field("mispredict_count_o", 32'(mispredict_count), 32'd0);
			@(posedge clk);
			#2;
		end

		for (int i = 0; i < n_entries; i++) begin
			if (!pending) begin
				query.valid = 1'b1;
				query.pc    = pc_tab[i];
				predict_model(pc_tab[i]);
				@(posedge clk);
				#2;
				query = '0;
			end
			wait_pred();
			if (timed_out) begin
				break;
			end
			check_field("pred_o.taken", 32'(pred.taken), 32'(exp_taken));
			check_field("pred_o.local_taken", 32'(pred.local_taken), 32'(exp_local));
			check_field("pred_o.global_taken", 32'(pred.global_taken), 32'(exp_global));
			check_field("pred_o.history", 32'(pred.history), 32'(exp_hist));

			// commit with the returned fields
			train.valid        = 1'b1;
			train.pc           = pc_tab[i];
			train.history      = pred.history;
			train.taken        = taken_tab[i];
			train.pred_taken   = pred.taken;
			train.local_taken  = pred.local_taken;
			train.global_taken = pred.global_taken;
			pending = (i + 1 < n_entries) && same_tab[i + 1];
			if (pending) begin
				// expected from the tables before this train
				query.valid = 1'b1;
				query.pc    = pc_tab[i + 1];
				predict_model(pc_tab[i + 1]);
			end
			@(posedge clk);
			#2;
			train_model(train);
			train = '0;
			query = '0;
			check_field("branch_count_o", 32'(branch_count), 32'(branch_m));
			check_field("mispredict_count_o", 32'(mispredict_count), 32'(misp_m));
			// valid lasts one cycle unless a new query overlapped the train
			check_field("pred_o.valid", 32'(pred.valid), 32'(pending));
		end

		$display("checks: %0d  errors: %0d  trains: %0d  mispredictions: %0d",
			checks, errors, branch_m, misp_m);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor import bp_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  bp_query_t query_i,
	input  bp_train_t train_i,
	output bp_pred_t  pred_o,
	output stat_t     branch_count_o,
	output stat_t     mispredict_count_o
);

	ctr_t     local_ctr;
	ctr_t     global_ctr;
	history_t query_history;

	//****************************************
	// component predictors
	//****************************************
	// local table, indexed by pc only
	counter_table local_table(
		//in
		.clk		(clk			),
		.reset_i	(reset_i		),
		.rd_index_i	(pc_index(query_i.pc)	),
		.wr_en_i	(train_i.valid		),
		.wr_index_i	(pc_index(train_i.pc)	),
		.wr_up_i	(train_i.taken		),
		//out
		.rd_ctr_o	(local_ctr		)
	);

	global_predictor global_predictor(
		//in
		.clk		(clk			),
		.reset_i	(reset_i		),
		.query_pc_i	(query_i.pc		),
		.train_i	(train_i		),
		//out
		.ctr_o		(global_ctr		),
		.history_o	(query_history		)
	);

	//****************************************
	// selection and statistics
	//****************************************
	tournament_chooser tournament_chooser(
		//in
		.clk		(clk			),
		.reset_i	(reset_i		),
		.query_i	(query_i		),
		.train_i	(train_i		),
		.local_ctr_i	(local_ctr		),
		.global_ctr_i	(global_ctr		),
		.history_i	(query_history		),
		//out
		.pred_o		(pred_o			)
	);

	prediction_stats prediction_stats(
		//in
		.clk			(clk			),
		.reset_i		(reset_i		),
		.train_i		(train_i		),
		//out
		.branch_count_o		(branch_count_o		),
		.mispredict_count_o	(mispredict_count_o	)
	);

endmodule

//--- prediction_stats.sv
`timescale 1ns/1ps

module prediction_stats import bp_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  bp_train_t train_i,
	output stat_t     branch_count_o,
	output stat_t     mispredict_count_o
);

	stat_t branch_q;
	stat_t mispredict_q;
	logic  wrapped_q;
	logic  mispredict;

	assign mispredict = train_i.valid && (train_i.pred_taken != train_i.taken);

	//****************************************
	// commit counters
	//****************************************
	always_ff @(posedge clk) begin
		if (reset_i) begin
			branch_q     <= '0;
			mispredict_q <= '0;
			wrapped_q    <= 1'b0;
		end else begin
			if (train_i.valid) begin
				branch_q <= branch_q + 1'b1;
				// sticky once the branch count rolls over
				if (&branch_q) begin
					wrapped_q <= 1'b1;
				end
			end
			if (mispredict) begin
				mispredict_q <= mispredict_q + 1'b1;
			end
		end
	end

	assign branch_count_o     = branch_q;
	assign mispredict_count_o = mispredict_q;

	a_mispredict_bounded: assert property (
		@(posedge clk) disable iff (reset_i)
		!wrapped_q |-> (mispredict_q <= branch_q)
	);

endmodule

//--- tournament_chooser.sv
`timescale 1ns/1ps

module tournament_chooser import bp_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  bp_query_t query_i,
	input  bp_train_t train_i,
	input  ctr_t      local_ctr_i,
	input  ctr_t      global_ctr_i,
	input  history_t  history_i,
	output bp_pred_t  pred_o
);

	ctr_t   choice_ctr;
	index_t query_index;
	index_t train_index;
	logic   disagree;
	logic   global_right;
	logic   pred_valid_q;
	logic   local_taken;
	logic   global_taken;

	//****************************************
	// chooser training
	//****************************************
	assign query_index  = pc_index(query_i.pc);
	assign train_index  = pc_index(train_i.pc);
	// only a split vote says which component is better
	assign disagree     = train_i.valid && (train_i.local_taken != train_i.global_taken);
	assign global_right = train_i.global_taken == train_i.taken;

	counter_table choice_table(
		//in
		.clk		(clk			),
		.reset_i	(reset_i		),
		.rd_index_i	(query_index		),
		.wr_en_i	(disagree		),
		.wr_index_i	(train_index		),
		.wr_up_i	(global_right		),
		//out
		.rd_ctr_o	(choice_ctr		)
	);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pred_valid_q <= 1'b0;
		end else begin
			pred_valid_q <= query_i.valid;
		end
	end

	//****************************************
	// final selection
	//****************************************
	assign local_taken  = ctr_taken(local_ctr_i);
	assign global_taken = ctr_taken(global_ctr_i);

	always_comb begin
		pred_o.valid        = pred_valid_q;
		pred_o.local_taken  = local_taken;
		pred_o.global_taken = global_taken;
		pred_o.taken        = ctr_taken(choice_ctr) ? global_taken : local_taken;
		pred_o.history      = history_i;
	end

	// one prediction per query, one cycle later
	a_pred_after_query: assert property (
		@(posedge clk) disable iff (reset_i)
		pred_o.valid |-> $past(query_i.valid)
	);

endmodule

//--- global_predictor.sv
`timescale 1ns/1ps

module global_predictor import bp_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  pc_t       query_pc_i,
	input  bp_train_t train_i,
	output ctr_t      ctr_o,
	output history_t  history_o
);

	history_t hist_q;
	history_t hist_snap_q;
	index_t   query_index;
	index_t   train_index;

	//****************************************
	// index hash
	//****************************************
	// query uses the live history, training the snapshot it was predicted with
	assign query_index = pc_index(query_pc_i) ^ hist_q;
	assign train_index = pc_index(train_i.pc) ^ train_i.history;

	//****************************************
	// history register
	//****************************************
	always_ff @(posedge clk) begin
		if (reset_i) begin
			hist_q <= '0;
		end else if (train_i.valid) begin
			hist_q <= {hist_q[HIST_W - 2:0], train_i.taken};
		end
	end

	// snapshot lines up with the table read
	always_ff @(posedge clk) begin
		hist_snap_q <= hist_q;
	end

	assign history_o = hist_snap_q;

	counter_table global_table(
		//in
		.clk		(clk			),
		.reset_i	(reset_i		),
		.rd_index_i	(query_index		),
		.wr_en_i	(train_i.valid		),
		.wr_index_i	(train_index		),
		.wr_up_i	(train_i.taken		),
		//out
		.rd_ctr_o	(ctr_o			)
	);

endmodule

//--- counter_table.sv
`timescale 1ns/1ps

module counter_table import bp_pkg::*; (
	input  logic   clk,
	input  logic   reset_i,
	input  index_t rd_index_i,
	input  logic   wr_en_i,
	input  index_t wr_index_i,
	input  logic   wr_up_i,
	output ctr_t   rd_ctr_o
);

	ctr_t ctr_q [DEPTH];
	ctr_t rd_ctr_q;
	ctr_t wr_ctr;
	ctr_t wr_next;

	//****************************************
	// saturating update
	//****************************************
	always_comb begin
		wr_ctr  = ctr_q[wr_index_i];
		wr_next = wr_ctr;
		if (wr_up_i && wr_ctr != CTR_MAX) begin
			wr_next = wr_ctr + 2'd1;
		end else if (!wr_up_i && wr_ctr != CTR_MIN) begin
			wr_next = wr_ctr - 2'd1;
		end
	end

	//****************************************
	// storage and registered read
	//****************************************
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < DEPTH; i++) begin
				ctr_q[i] <= CTR_RESET;
			end
			rd_ctr_q <= CTR_RESET;
		end else begin
			// read sees the value from before a write at this edge
			rd_ctr_q <= ctr_q[rd_index_i];
			if (wr_en_i) begin
				ctr_q[wr_index_i] <= wr_next;
			end
		end
	end

	assign rd_ctr_o = rd_ctr_q;

	// a write with an unknown index would corrupt an arbitrary entry
	a_wr_index_known: assert property (
		@(posedge clk) disable iff (reset_i)
		wr_en_i |-> !$isunknown(wr_index_i)
	);

endmodule

//--- bp_pkg.sv
package bp_pkg;

	//****************************************
	// widths
	//****************************************
	localparam int PC_W      = 32;
	localparam int INDEX_W   = 6;
	localparam int INDEX_LSB = 2;
	localparam int HIST_W    = INDEX_W;
	localparam int STAT_W    = 16;
	localparam int DEPTH     = 1 << INDEX_W;

	typedef logic [PC_W - 1:0]    pc_t;
	typedef logic [INDEX_W - 1:0] index_t;
	// newest outcome in bit 0
	typedef logic [HIST_W - 1:0]  history_t;
	typedef logic [1:0]           ctr_t;
	typedef logic [STAT_W - 1:0]  stat_t;

	//****************************************
	// counter encoding
	//****************************************
	// weakly not taken, weakly local for the chooser
	localparam ctr_t CTR_RESET = 2'd1;
	localparam ctr_t CTR_MIN   = 2'd0;
	localparam ctr_t CTR_MAX   = 2'd3;
	localparam ctr_t CTR_TAKEN = 2'd2;

	//****************************************
	// handshake bundles
	//****************************************
	typedef struct packed {
		logic valid;
		pc_t  pc;
	} bp_query_t;

	typedef struct packed {
		logic     valid;
		logic     taken;
		logic     local_taken;
		logic     global_taken;
		history_t history;
	} bp_pred_t;

	// fields of an earlier prediction plus the resolved outcome
	typedef struct packed {
		logic     valid;
		pc_t      pc;
		history_t history;
		logic     taken;
		logic     pred_taken;
		logic     local_taken;
		logic     global_taken;
	} bp_train_t;

	// table index from pc bits 7..2
	function automatic index_t pc_index(input pc_t pc);
		return pc[INDEX_LSB +: INDEX_W];
	endfunction

	function automatic logic ctr_taken(input ctr_t ctr);
		return ctr >= CTR_TAKEN;
	endfunction

endpackage
